// ==== hdl/riscv_defs.svh ====
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// Datapath and register file geometry.
`define RISCV_XLEN        32
`define RISCV_REGADDR_W   5

`define RISCV_OP_LUI      7'b0110111

// One quotient or partial-product bit per iteration.
`define RISCV_MD_CYCLES   32

`endif

// ==== hdl/riscv_pkg.sv ====
`default_nettype none

`include "riscv_defs.svh"

package riscv_pkg;

  typedef logic [`RISCV_XLEN-1:0]      word_t;
  typedef logic [`RISCV_REGADDR_W-1:0] regaddr_t;
  typedef logic [6:0]                  opcode_t;

  // 2 selects a load.
  typedef logic [1:0]                  resultsrc_t;

  // 0 regfile, 1 writeback, 2 memory result, 3 memory upper immediate.
  typedef logic [1:0]                  fwdsel_t;

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } md_state_t;

endpackage

`default_nettype wire

// ==== hdl/riscv_hazardunit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defs.svh"

module riscv_hazardunit (
  input  riscv_pkg::regaddr_t   i_rs1addr_d,
  input  riscv_pkg::regaddr_t   i_rs2addr_d,
  input  riscv_pkg::regaddr_t   i_rs1addr_e,
  input  riscv_pkg::regaddr_t   i_rs2addr_e,
  input  riscv_pkg::regaddr_t   i_rdaddr_e,
  input  riscv_pkg::regaddr_t   i_rdaddr_m,
  input  riscv_pkg::regaddr_t   i_rdaddr_w,
  input  riscv_pkg::regaddr_t   i_rs1addr_m,
  input  riscv_pkg::opcode_t    i_opcode_m,
  input  riscv_pkg::resultsrc_t i_resultsrc_e,
  input  logic                  i_regw_m,
  input  logic                  i_regw_w,
  input  logic                  i_pcsrc,
  input  logic                  i_dcache_stall_m,
  input  logic                  i_mul_en_e,
  input  logic                  i_div_en_e,
  input  logic                  i_md_valid,
  input  logic                  i_iscsr_d,
  input  logic                  i_iscsr_e,
  input  logic                  i_iscsr_m,
  input  logic                  i_iscsr_w,
  output riscv_pkg::fwdsel_t    o_fwda,
  output riscv_pkg::fwdsel_t    o_fwdb,
  output logic                  o_stallpc,
  output logic                  o_stallfd,
  output logic                  o_flushfd,
  output logic                  o_flushde,
  output logic                  o_stallde,
  output logic                  o_stallem,
  output logic                  o_stallmw,
  output logic                  o_passwb
);

  logic wr_m;
  logic wr_w;
  logic lui_m;
  logic use_src_e;
  logic use_hit_stall;
  logic use_hit_flush;
  logic md_stall;
  logic glob_stall;

  assign wr_m  = i_regw_m && (i_rdaddr_m != '0);   // x0 never forwards.
  assign wr_w  = i_regw_w && (i_rdaddr_w != '0);
  assign lui_m = (i_opcode_m == `RISCV_OP_LUI);

  function automatic riscv_pkg::fwdsel_t fwd_sel(input riscv_pkg::regaddr_t rs);
    riscv_pkg::fwdsel_t sel;
    if (wr_m && (rs == i_rdaddr_m) && lui_m)
    begin
      sel = 2'd3;
    end
    else if (wr_m && (rs == i_rdaddr_m))
    begin
      sel = 2'd2;
    end
    else if (wr_w && (rs == i_rdaddr_w))
    begin
      sel = 2'd1;
    end
    else
    begin
      sel = 2'd0;
    end
    return sel;
  endfunction

  always_comb
  begin
    o_fwda = fwd_sel(i_rs1addr_e);
    o_fwdb = fwd_sel(i_rs2addr_e);
  end

  // Producer in execute whose value is not ready yet: a load, or a CSR
  // feeding a non-CSR consumer.
  assign use_src_e = (i_resultsrc_e == 2'd2) || (i_iscsr_e && !i_iscsr_d);

  // A CSR consumer only reads rs1, so rs2 is ignored for it here.
  assign use_hit_stall = use_src_e &&
                         ((i_rs1addr_d == i_rdaddr_e) ||
                          ((i_rs2addr_d == i_rdaddr_e) && !i_iscsr_d));

  assign use_hit_flush = use_src_e &&
                         ((i_rs1addr_d == i_rdaddr_e) || (i_rs2addr_d == i_rdaddr_e));

  assign md_stall   = (i_mul_en_e || i_div_en_e) && !i_md_valid;
  assign glob_stall = i_dcache_stall_m || md_stall;

  assign o_stallpc = use_hit_stall || glob_stall;
  assign o_stallfd = use_hit_stall || glob_stall;
  assign o_flushfd = i_pcsrc;
  assign o_flushde = use_hit_flush || i_pcsrc;   // Bubble into execute.

  assign o_stallde = glob_stall;
  assign o_stallem = glob_stall;
  assign o_stallmw = glob_stall;

  // CSR in memory reading the value a CSR in writeback is still writing.
  assign o_passwb = i_iscsr_m && i_iscsr_w && (i_rdaddr_w == i_rs1addr_m);

endmodule

`default_nettype wire

// ==== hdl/riscv_ctrlpipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_ctrlpipe (
  input  logic                  i_riscv_clk,
  input  logic                  i_rst,
  input  riscv_pkg::regaddr_t   i_rs1addr_d,
  input  riscv_pkg::regaddr_t   i_rs2addr_d,
  input  riscv_pkg::regaddr_t   i_rdaddr_d,
  input  logic                  i_regw_d,
  input  riscv_pkg::resultsrc_t i_resultsrc_d,
  input  riscv_pkg::opcode_t    i_opcode_d,
  input  logic                  i_iscsr_d,
  input  logic                  i_mul_en_d,
  input  logic                  i_div_en_d,
  input  logic                  i_stallde,
  input  logic                  i_flushde,
  input  logic                  i_stallem,
  input  logic                  i_stallmw,
  output riscv_pkg::regaddr_t   o_rs1addr_e,
  output riscv_pkg::regaddr_t   o_rs2addr_e,
  output riscv_pkg::regaddr_t   o_rdaddr_e,
  output riscv_pkg::resultsrc_t o_resultsrc_e,
  output logic                  o_iscsr_e,
  output logic                  o_mul_en_e,
  output logic                  o_div_en_e,
  output riscv_pkg::regaddr_t   o_rdaddr_m,
  output logic                  o_regw_m,
  output riscv_pkg::opcode_t    o_opcode_m,
  output logic                  o_iscsr_m,
  output riscv_pkg::regaddr_t   o_rs1addr_m,
  output riscv_pkg::regaddr_t   o_rdaddr_w,
  output logic                  o_regw_w,
  output logic                  o_iscsr_w
);

  logic               regw_e;
  riscv_pkg::opcode_t opcode_e;

  // D/E. A stall holds even when a flush is requested in the same cycle.
  always_ff @(posedge i_riscv_clk)
  begin
    if (i_rst || (i_flushde && !i_stallde))
    begin
      o_rs1addr_e   <= '0;
      o_rs2addr_e   <= '0;
      o_rdaddr_e    <= '0;
      regw_e        <= 1'b0;
      o_resultsrc_e <= '0;
      opcode_e      <= '0;
      o_iscsr_e     <= 1'b0;
      o_mul_en_e    <= 1'b0;
      o_div_en_e    <= 1'b0;
    end
    else if (!i_stallde)
    begin
      o_rs1addr_e   <= i_rs1addr_d;
      o_rs2addr_e   <= i_rs2addr_d;
      o_rdaddr_e    <= i_rdaddr_d;
      regw_e        <= i_regw_d;
      o_resultsrc_e <= i_resultsrc_d;
      opcode_e      <= i_opcode_d;
      o_iscsr_e     <= i_iscsr_d;
      o_mul_en_e    <= i_mul_en_d;
      o_div_en_e    <= i_div_en_d;
    end
  end

  // E/M.
  always_ff @(posedge i_riscv_clk)
  begin
    if (i_rst)
    begin
      o_rdaddr_m  <= '0;
      o_regw_m    <= 1'b0;
      o_opcode_m  <= '0;
      o_iscsr_m   <= 1'b0;
      o_rs1addr_m <= '0;
    end
    else if (!i_stallem)
    begin
      o_rdaddr_m  <= o_rdaddr_e;
      o_regw_m    <= regw_e;
      o_opcode_m  <= opcode_e;
      o_iscsr_m   <= o_iscsr_e;
      o_rs1addr_m <= o_rs1addr_e;   // Needed for the CSR pass check.
    end
  end

  // M/W.
  always_ff @(posedge i_riscv_clk)
  begin
    if (i_rst)
    begin
      o_rdaddr_w <= '0;
      o_regw_w   <= 1'b0;
      o_iscsr_w  <= 1'b0;
    end
    else if (!i_stallmw)
    begin
      o_rdaddr_w <= o_rdaddr_m;
      o_regw_w   <= o_regw_m;
      o_iscsr_w  <= o_iscsr_m;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/riscv_opfwd.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_opfwd (
  input  riscv_pkg::fwdsel_t i_fwda,
  input  riscv_pkg::fwdsel_t i_fwdb,
  input  riscv_pkg::word_t   i_rs1data_e,
  input  riscv_pkg::word_t   i_rs2data_e,
  input  riscv_pkg::word_t   i_result_m,
  input  riscv_pkg::word_t   i_uimm_m,
  input  riscv_pkg::word_t   i_result_w,
  output riscv_pkg::word_t   o_srca_e,
  output riscv_pkg::word_t   o_srcb_e
);

  function automatic riscv_pkg::word_t fwd_mux(input riscv_pkg::fwdsel_t sel,
                                               input riscv_pkg::word_t   regdata);
    riscv_pkg::word_t val;
    case (sel)
      2'd1:    val = i_result_w;
      2'd2:    val = i_result_m;
      2'd3:    val = i_uimm_m;   // LUI result is just the upper immediate.
      default: val = regdata;
    endcase
    return val;
  endfunction

  always_comb
  begin
    o_srca_e = fwd_mux(i_fwda, i_rs1data_e);
    o_srcb_e = fwd_mux(i_fwdb, i_rs2data_e);
  end

endmodule

`default_nettype wire

// ==== hdl/riscv_muldiv.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defs.svh"

module riscv_muldiv (
  input  logic             i_riscv_clk,
  input  logic             i_rst,
  input  logic             i_mul_en,
  input  logic             i_div_en,
  input  logic             i_stallde,
  input  riscv_pkg::word_t i_srca,
  input  riscv_pkg::word_t i_srcb,
  output riscv_pkg::word_t o_result,
  output logic             o_valid
);

  localparam int CNT_W = $clog2(`RISCV_MD_CYCLES);

  riscv_pkg::md_state_t state;
  logic [CNT_W-1:0]     cnt;
  logic                 is_div;
  riscv_pkg::word_t     acc;   // Product or quotient.
  riscv_pkg::word_t     rem;   // Multiplier or remainder.
  riscv_pkg::word_t     opd;   // Multiplicand or divisor.
  logic                 s_div;
  riscv_pkg::word_t     s_acc;
  riscv_pkg::word_t     s_rem;
  riscv_pkg::word_t     s_opd;
  riscv_pkg::word_t     n_acc;
  riscv_pkg::word_t     n_rem;
  riscv_pkg::word_t     n_opd;
  logic [`RISCV_XLEN:0] rem_sh;
  logic [`RISCV_XLEN:0] diff;

  // The first iteration runs on the start edge straight from the operands.
  always_comb
  begin
    if (state == riscv_pkg::IDLE)
    begin
      s_div = i_div_en;
      s_acc = i_div_en ? i_srca : '0;
      s_rem = i_div_en ? '0 : i_srcb;
      s_opd = i_div_en ? i_srcb : i_srca;
    end
    else
    begin
      s_div = is_div;
      s_acc = acc;
      s_rem = rem;
      s_opd = opd;
    end
  end

  // Zero divisor never fails the compare, so the quotient fills with ones.
  assign rem_sh = {s_rem, s_acc[`RISCV_XLEN-1]};
  assign diff   = rem_sh - {1'b0, s_opd};

  always_comb
  begin
    if (s_div)
    begin
      n_acc = {s_acc[`RISCV_XLEN-2:0], ~diff[`RISCV_XLEN]};
      n_rem = diff[`RISCV_XLEN] ? rem_sh[`RISCV_XLEN-1:0] : diff[`RISCV_XLEN-1:0];
      n_opd = s_opd;
    end
    else
    begin
      n_acc = s_rem[0] ? s_acc + s_opd : s_acc;
      n_rem = s_rem >> 1;
      n_opd = s_opd << 1;
    end
  end

  always_ff @(posedge i_riscv_clk)
  begin
    if (i_rst)
    begin
      state  <= riscv_pkg::IDLE;
      cnt    <= '0;
      is_div <= 1'b0;
    end
    else
    begin
      case (state)
        riscv_pkg::IDLE:
        begin
          if (i_mul_en || i_div_en)
          begin
            state  <= riscv_pkg::BUSY;
            cnt    <= CNT_W'(1);
            is_div <= i_div_en;
          end
        end
        riscv_pkg::BUSY:
        begin
          cnt <= cnt + CNT_W'(1);
          if (cnt == CNT_W'(`RISCV_MD_CYCLES - 1))
            state <= riscv_pkg::DONE;
        end
        default:
        begin
          if (!i_stallde)
            state <= riscv_pkg::IDLE;   // Execute moves on.
        end
      endcase
    end
  end

  always_ff @(posedge i_riscv_clk)
  begin
    if (state == riscv_pkg::BUSY || (state == riscv_pkg::IDLE && (i_mul_en || i_div_en)))
    begin
      acc <= n_acc;
      rem <= n_rem;
      opd <= n_opd;
    end
  end

  assign o_result = acc;
  assign o_valid  = (state == riscv_pkg::DONE);

endmodule

`default_nettype wire

// ==== hdl/riscv_pipectrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_pipectrl_top (
  input  logic                  i_riscv_clk,
  input  logic                  i_rst,
  input  riscv_pkg::regaddr_t   i_riscv_rs1addr_d,
  input  riscv_pkg::regaddr_t   i_riscv_rs2addr_d,
  input  riscv_pkg::regaddr_t   i_riscv_rdaddr_d,
  input  logic                  i_riscv_regw_d,
  input  riscv_pkg::resultsrc_t i_riscv_resultsrc_d,
  input  riscv_pkg::opcode_t    i_riscv_opcode_d,
  input  logic                  i_riscv_iscsr_d,
  input  logic                  i_riscv_mul_en_d,
  input  logic                  i_riscv_div_en_d,
  input  logic                  i_riscv_pcsrc,
  input  logic                  i_riscv_dcache_stall_m,
  input  riscv_pkg::word_t      i_riscv_rs1data_e,
  input  riscv_pkg::word_t      i_riscv_rs2data_e,
  input  riscv_pkg::word_t      i_riscv_result_m,
  input  riscv_pkg::word_t      i_riscv_uimm_m,
  input  riscv_pkg::word_t      i_riscv_result_w,
  output logic                  o_riscv_stallpc,
  output logic                  o_riscv_stallfd,
  output logic                  o_riscv_flushfd,
  output logic                  o_riscv_flushde,
  output logic                  o_riscv_stallde,
  output logic                  o_riscv_stallem,
  output logic                  o_riscv_stallmw,
  output logic                  o_riscv_passwb,
  output riscv_pkg::word_t      o_riscv_srca_e,
  output riscv_pkg::word_t      o_riscv_srcb_e,
  output riscv_pkg::word_t      o_riscv_mdresult,
  output logic                  o_riscv_mdvalid
);

  riscv_pkg::regaddr_t   rs1addr_e;
  riscv_pkg::regaddr_t   rs2addr_e;
  riscv_pkg::regaddr_t   rdaddr_e;
  riscv_pkg::regaddr_t   rdaddr_m;
  riscv_pkg::regaddr_t   rs1addr_m;
  riscv_pkg::regaddr_t   rdaddr_w;
  riscv_pkg::resultsrc_t resultsrc_e;
  riscv_pkg::opcode_t    opcode_m;
  riscv_pkg::fwdsel_t    fwda;
  riscv_pkg::fwdsel_t    fwdb;
  logic                  iscsr_e;
  logic                  iscsr_m;
  logic                  iscsr_w;
  logic                  regw_m;
  logic                  regw_w;
  logic                  mul_en_e;
  logic                  div_en_e;

  riscv_ctrlpipe u_ctrlpipe (
    .i_riscv_clk   (i_riscv_clk),
    .i_rst         (i_rst),
    .i_rs1addr_d   (i_riscv_rs1addr_d),
    .i_rs2addr_d   (i_riscv_rs2addr_d),
    .i_rdaddr_d    (i_riscv_rdaddr_d),
    .i_regw_d      (i_riscv_regw_d),
    .i_resultsrc_d (i_riscv_resultsrc_d),
    .i_opcode_d    (i_riscv_opcode_d),
    .i_iscsr_d     (i_riscv_iscsr_d),
    .i_mul_en_d    (i_riscv_mul_en_d),
    .i_div_en_d    (i_riscv_div_en_d),
    .i_stallde     (o_riscv_stallde),
    .i_flushde     (o_riscv_flushde),
    .i_stallem     (o_riscv_stallem),
    .i_stallmw     (o_riscv_stallmw),
    .o_rs1addr_e   (rs1addr_e),
    .o_rs2addr_e   (rs2addr_e),
    .o_rdaddr_e    (rdaddr_e),
    .o_resultsrc_e (resultsrc_e),
    .o_iscsr_e     (iscsr_e),
    .o_mul_en_e    (mul_en_e),
    .o_div_en_e    (div_en_e),
    .o_rdaddr_m    (rdaddr_m),
    .o_regw_m      (regw_m),
    .o_opcode_m    (opcode_m),
    .o_iscsr_m     (iscsr_m),
    .o_rs1addr_m   (rs1addr_m),
    .o_rdaddr_w    (rdaddr_w),
    .o_regw_w      (regw_w),
    .o_iscsr_w     (iscsr_w)
  );

  riscv_hazardunit u_hazardunit (
    .i_rs1addr_d      (i_riscv_rs1addr_d),
    .i_rs2addr_d      (i_riscv_rs2addr_d),
    .i_rs1addr_e      (rs1addr_e),
    .i_rs2addr_e      (rs2addr_e),
    .i_rdaddr_e       (rdaddr_e),
    .i_rdaddr_m       (rdaddr_m),
    .i_rdaddr_w       (rdaddr_w),
    .i_rs1addr_m      (rs1addr_m),
    .i_opcode_m       (opcode_m),
    .i_resultsrc_e    (resultsrc_e),
    .i_regw_m         (regw_m),
    .i_regw_w         (regw_w),
    .i_pcsrc          (i_riscv_pcsrc),
    .i_dcache_stall_m (i_riscv_dcache_stall_m),
    .i_mul_en_e       (mul_en_e),
    .i_div_en_e       (div_en_e),
    .i_md_valid       (o_riscv_mdvalid),
    .i_iscsr_d        (i_riscv_iscsr_d),
    .i_iscsr_e        (iscsr_e),
    .i_iscsr_m        (iscsr_m),
    .i_iscsr_w        (iscsr_w),
    .o_fwda           (fwda),
    .o_fwdb           (fwdb),
    .o_stallpc        (o_riscv_stallpc),
    .o_stallfd        (o_riscv_stallfd),
    .o_flushfd        (o_riscv_flushfd),
    .o_flushde        (o_riscv_flushde),
    .o_stallde        (o_riscv_stallde),
    .o_stallem        (o_riscv_stallem),
    .o_stallmw        (o_riscv_stallmw),
    .o_passwb         (o_riscv_passwb)
  );

  riscv_opfwd u_opfwd (
    .i_fwda      (fwda),
    .i_fwdb      (fwdb),
    .i_rs1data_e (i_riscv_rs1data_e),
    .i_rs2data_e (i_riscv_rs2data_e),
    .i_result_m  (i_riscv_result_m),
    .i_uimm_m    (i_riscv_uimm_m),
    .i_result_w  (i_riscv_result_w),
    .o_srca_e    (o_riscv_srca_e),
    .o_srcb_e    (o_riscv_srcb_e)
  );

  // Works on the forwarded operands, so a dependent mul/div needs no stall.
  riscv_muldiv u_muldiv (
    .i_riscv_clk (i_riscv_clk),
    .i_rst       (i_rst),
    .i_mul_en    (mul_en_e),
    .i_div_en    (div_en_e),
    .i_stallde   (o_riscv_stallde),
    .i_srca      (o_riscv_srca_e),
    .i_srcb      (o_riscv_srcb_e),
    .o_result    (o_riscv_mdresult),
    .o_valid     (o_riscv_mdvalid)
  );

endmodule

`default_nettype wire

// ==== testbench/riscv_pipectrl_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_pipectrl_assertions (
  input logic                i_clk,
  input logic                i_rst,
  input riscv_pkg::regaddr_t i_rdaddr_m,
  input riscv_pkg::regaddr_t i_rdaddr_w,
  input riscv_pkg::fwdsel_t  i_fwda,
  input riscv_pkg::fwdsel_t  i_fwdb,
  input logic                i_flushfd,
  input logic                i_flushde,
  input logic                i_stallde,
  input logic                i_stallpc
);

  flush_pair: assert property (@(posedge i_clk) disable iff (i_rst) i_flushfd |-> i_flushde)
    else $error("F/D flush without D/E flush");

  // Global stall freezes the front end too.
  stall_pair: assert property (@(posedge i_clk) disable iff (i_rst) i_stallde |-> i_stallpc)
    else $error("D/E stall without PC stall");

  fwda_mem: assert property (@(posedge i_clk) disable iff (i_rst)
                             (i_fwda == 2'd2 || i_fwda == 2'd3) |-> (i_rdaddr_m != '0))
    else $error("Operand A forwarded from memory stage with rd x0");

  fwda_wb: assert property (@(posedge i_clk) disable iff (i_rst)
                            (i_fwda == 2'd1) |-> (i_rdaddr_w != '0))
    else $error("Operand A forwarded from writeback stage with rd x0");

  fwdb_mem: assert property (@(posedge i_clk) disable iff (i_rst)
                             (i_fwdb == 2'd2 || i_fwdb == 2'd3) |-> (i_rdaddr_m != '0))
    else $error("Operand B forwarded from memory stage with rd x0");

  fwdb_wb: assert property (@(posedge i_clk) disable iff (i_rst)
                            (i_fwdb == 2'd1) |-> (i_rdaddr_w != '0))
    else $error("Operand B forwarded from writeback stage with rd x0");

endmodule

// Hazard unit outputs and pipeline addresses as seen in the top level.
bind riscv_pipectrl_top riscv_pipectrl_assertions u_hazard_sva (
  .i_clk      (i_riscv_clk),
  .i_rst      (i_rst),
  .i_rdaddr_m (rdaddr_m),
  .i_rdaddr_w (rdaddr_w),
  .i_fwda     (fwda),
  .i_fwdb     (fwdb),
  .i_flushfd  (o_riscv_flushfd),
  .i_flushde  (o_riscv_flushde),
  .i_stallde  (o_riscv_stallde),
  .i_stallpc  (o_riscv_stallpc)
);

`default_nettype wire

// ==== testbench/riscv_pipectrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defs.svh"

module riscv_pipectrl_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam riscv_pkg::opcode_t OP_REG    = 7'b0110011;
  localparam riscv_pkg::opcode_t OP_LOAD   = 7'b0000011;
  localparam riscv_pkg::opcode_t OP_SYSTEM = 7'b1110011;

  // Reset, reset check, six forwarding cases, load, branch, CSR, four mul/div runs.
  localparam int TEST_CYCLES = RESET_CYCLES + 1 + 6 * 4 + 4 + 2 + 10 +
                               4 * (`RISCV_MD_CYCLES + 4) + 3;
  localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * CLK_PERIOD;

  logic                  clk;
  logic                  rst;
  riscv_pkg::regaddr_t   rs1addr_d;
  riscv_pkg::regaddr_t   rs2addr_d;
  riscv_pkg::regaddr_t   rdaddr_d;
  logic                  regw_d;
  riscv_pkg::resultsrc_t resultsrc_d;
  riscv_pkg::opcode_t    opcode_d;
  logic                  iscsr_d;
  logic                  mul_en_d;
  logic                  div_en_d;
  logic                  pcsrc;
  logic                  dcache_stall;
  riscv_pkg::word_t      rs1data_e;
  riscv_pkg::word_t      rs2data_e;
  riscv_pkg::word_t      result_m;
  riscv_pkg::word_t      uimm_m;
  riscv_pkg::word_t      result_w;
  logic                  stallpc;
  logic                  stallfd;
  logic                  flushfd;
  logic                  flushde;
  logic                  stallde;
  logic                  stallem;
  logic                  stallmw;
  logic                  passwb;
  riscv_pkg::word_t      srca_e;
  riscv_pkg::word_t      srcb_e;
  riscv_pkg::word_t      mdresult;
  logic                  mdvalid;

  int errors;
  int tests_run;
  int tests_failed;

  riscv_pipectrl_top UUT (
    .i_riscv_clk            (clk),
    .i_rst                  (rst),
    .i_riscv_rs1addr_d      (rs1addr_d),
    .i_riscv_rs2addr_d      (rs2addr_d),
    .i_riscv_rdaddr_d       (rdaddr_d),
    .i_riscv_regw_d         (regw_d),
    .i_riscv_resultsrc_d    (resultsrc_d),
    .i_riscv_opcode_d       (opcode_d),
    .i_riscv_iscsr_d        (iscsr_d),
    .i_riscv_mul_en_d       (mul_en_d),
    .i_riscv_div_en_d       (div_en_d),
    .i_riscv_pcsrc          (pcsrc),
    .i_riscv_dcache_stall_m (dcache_stall),
    .i_riscv_rs1data_e      (rs1data_e),
    .i_riscv_rs2data_e      (rs2data_e),
    .i_riscv_result_m       (result_m),
    .i_riscv_uimm_m         (uimm_m),
    .i_riscv_result_w       (result_w),
    .o_riscv_stallpc        (stallpc),
    .o_riscv_stallfd        (stallfd),
    .o_riscv_flushfd        (flushfd),
    .o_riscv_flushde        (flushde),
    .o_riscv_stallde        (stallde),
    .o_riscv_stallem        (stallem),
    .o_riscv_stallmw        (stallmw),
    .o_riscv_passwb         (passwb),
    .o_riscv_srca_e         (srca_e),
    .o_riscv_srcb_e         (srcb_e),
    .o_riscv_mdresult       (mdresult),
    .o_riscv_mdvalid        (mdvalid)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

  task automatic check_word(input string name, input riscv_pkg::word_t exp,
                            input riscv_pkg::word_t act);
    if (act !== exp)
    begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_sel(input string name, input riscv_pkg::fwdsel_t exp,
                           input riscv_pkg::fwdsel_t act);
    if (act !== exp)
    begin
      errors++;
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Recovers the forward select from which source value reached the operand.
  function automatic riscv_pkg::fwdsel_t source_of(input riscv_pkg::word_t v,
                                                   input riscv_pkg::word_t regdata);
    riscv_pkg::fwdsel_t sel;
    if (v == uimm_m)
      sel = 2'd3;
    else if (v == result_m)
      sel = 2'd2;
    else if (v == result_w)
      sel = 2'd1;
    else
      sel = 2'd0;   // Register data, or no known source.
    if (sel == 2'd0 && v != regdata)
    begin
      errors++;
      $display("Operand %h matches none of the forwarding sources", v);
    end
    return sel;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_decode(input riscv_pkg::regaddr_t rs1, input riscv_pkg::regaddr_t rs2,
                              input riscv_pkg::regaddr_t rd, input logic regw,
                              input riscv_pkg::resultsrc_t rsrc, input riscv_pkg::opcode_t op,
                              input logic csr, input logic mul, input logic div);
    rs1addr_d   = rs1;
    rs2addr_d   = rs2;
    rdaddr_d    = rd;
    regw_d      = regw;
    resultsrc_d = rsrc;
    opcode_d    = op;
    iscsr_d     = csr;
    mul_en_d    = mul;
    div_en_d    = div;
  endtask

  task automatic drive_bubble();
    drive_decode(5'd0, 5'd0, 5'd0, 1'b0, 2'd0, 7'd0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic check_stalls(input string name, input logic exp);
    check_bit({name, " stallpc"}, exp, stallpc);
    check_bit({name, " stallfd"}, exp, stallfd);
    check_bit({name, " stallde"}, exp, stallde);
    check_bit({name, " stallem"}, exp, stallem);
    check_bit({name, " stallmw"}, exp, stallmw);
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start)
    begin
      $display("Test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - errs_at_start);
    end
  endtask

  task automatic test_reset();
    int errs;
    errs = errors;
    #1;
    check_stalls("reset", 1'b0);
    check_bit("reset flushfd", 1'b0, flushfd);
    check_bit("reset flushde", 1'b0, flushde);
    check_bit("reset passwb", 1'b0, passwb);
    check_bit("reset mdvalid", 1'b0, mdvalid);
    finish_test("reset", errs);
  endtask

  // Producer for writeback, producer for memory, then the consumer into execute.
  task automatic fwd_case(input string name,
                          input riscv_pkg::regaddr_t rd_w, input logic regw_w,
                          input riscv_pkg::regaddr_t rd_m, input logic regw_m,
                          input logic lui_m,
                          input riscv_pkg::regaddr_t rs1, input riscv_pkg::regaddr_t rs2,
                          input riscv_pkg::fwdsel_t exp_a, input riscv_pkg::fwdsel_t exp_b);
    step();
    drive_decode(5'd0, 5'd0, rd_w, regw_w, 2'd0, OP_REG, 1'b0, 1'b0, 1'b0);
    step();
    drive_decode(5'd0, 5'd0, rd_m, regw_m, 2'd0, lui_m ? `RISCV_OP_LUI : OP_REG,
                 1'b0, 1'b0, 1'b0);
    step();
    drive_decode(rs1, rs2, 5'd0, 1'b0, 2'd0, OP_REG, 1'b0, 1'b0, 1'b0);
    step();
    drive_bubble();
    #1;
    check_sel({"forwarding ", name, " srca"}, exp_a, source_of(srca_e, rs1data_e));
    check_sel({"forwarding ", name, " srcb"}, exp_b, source_of(srcb_e, rs2data_e));
  endtask

  task automatic test_forwarding();
    int errs;
    errs = errors;
    fwd_case("lui_and_wb", 5'd6, 1'b1, 5'd5, 1'b1, 1'b1, 5'd5, 5'd6, 2'd3, 2'd1);
    fwd_case("mem_over_wb", 5'd9, 1'b1, 5'd9, 1'b1, 1'b0, 5'd9, 5'd4, 2'd2, 2'd0);
    fwd_case("lui_over_wb", 5'd7, 1'b1, 5'd7, 1'b1, 1'b1, 5'd3, 5'd7, 2'd0, 2'd3);
    fwd_case("x0", 5'd0, 1'b1, 5'd0, 1'b1, 1'b1, 5'd0, 5'd0, 2'd0, 2'd0);
    fwd_case("no_write", 5'd10, 1'b0, 5'd11, 1'b0, 1'b0, 5'd10, 5'd11, 2'd0, 2'd0);
    fwd_case("wb_and_mem", 5'd12, 1'b1, 5'd13, 1'b1, 1'b0, 5'd12, 5'd13, 2'd1, 2'd2);
    finish_test("forwarding", errs);
  endtask

  task automatic test_load_use();
    int errs;
    errs = errors;
    step();
    drive_decode(5'd0, 5'd0, 5'd12, 1'b1, 2'd2, OP_LOAD, 1'b0, 1'b0, 1'b0);
    step();
    drive_decode(5'd12, 5'd3, 5'd14, 1'b1, 2'd0, OP_REG, 1'b0, 1'b0, 1'b0);
    #1;
    check_bit("load_use stallpc", 1'b1, stallpc);
    check_bit("load_use stallfd", 1'b1, stallfd);
    check_bit("load_use flushde", 1'b1, flushde);
    check_bit("load_use stallde", 1'b0, stallde);
    step();   // Bubble in execute, consumer held in decode.
    #1;
    check_bit("load_use stallpc after", 1'b0, stallpc);
    check_bit("load_use flushde after", 1'b0, flushde);
    step();
    drive_bubble();
    #1;
    check_sel("load_use srca", 2'd1, source_of(srca_e, rs1data_e));
    check_sel("load_use srcb", 2'd0, source_of(srcb_e, rs2data_e));
    finish_test("load_use", errs);
  endtask

  task automatic test_branch();
    int errs;
    errs = errors;
    step();
    pcsrc = 1'b1;
    #1;
    check_bit("branch flushfd", 1'b1, flushfd);
    check_bit("branch flushde", 1'b1, flushde);
    check_stalls("branch", 1'b0);
    step();
    pcsrc = 1'b0;
    #1;
    check_bit("branch flushfd released", 1'b0, flushfd);
    finish_test("branch", errs);
  endtask

  task automatic test_csr();
    int errs;
    errs = errors;
    step();
    drive_decode(5'd0, 5'd0, 5'd20, 1'b1, 2'd0, OP_SYSTEM, 1'b1, 1'b0, 1'b0);
    step();
    drive_decode(5'd20, 5'd0, 5'd21, 1'b1, 2'd0, OP_SYSTEM, 1'b1, 1'b0, 1'b0);
    #1;
    check_bit("csr csr_after_csr stallpc", 1'b0, stallpc);
    step();
    drive_bubble();
    step();
    #1;
    check_bit("csr passwb", 1'b1, passwb);
    step();
    #1;
    check_bit("csr passwb cleared", 1'b0, passwb);
    // Non-CSR consumer reading the CSR destination through rs2.
    step();
    drive_decode(5'd0, 5'd0, 5'd22, 1'b1, 2'd0, OP_SYSTEM, 1'b1, 1'b0, 1'b0);
    step();
    drive_decode(5'd3, 5'd22, 5'd23, 1'b1, 2'd0, OP_REG, 1'b0, 1'b0, 1'b0);
    #1;
    check_bit("csr use stallpc", 1'b1, stallpc);
    check_bit("csr use stallfd", 1'b1, stallfd);
    check_bit("csr use flushde", 1'b1, flushde);
    step();
    #1;
    check_bit("csr use stallpc after", 1'b0, stallpc);
    step();
    drive_bubble();
    finish_test("csr", errs);
  endtask

  task automatic run_muldiv(input string name, input logic div, input riscv_pkg::word_t a,
                            input riscv_pkg::word_t b, input int hold);
    riscv_pkg::word_t exp_res;
    int               cycles;
    int               i;
    int               errs;
    errs = errors;
    if (!div)
      exp_res = a * b;
    else if (b == '0)
      exp_res = '1;
    else
      exp_res = a / b;
    step();
    drive_decode(5'd13, 5'd14, 5'd15, 1'b1, 2'd0, OP_REG, 1'b0, !div, div);
    rs1data_e = a;
    rs2data_e = b;
    step();   // Instruction now in execute.
    drive_bubble();
    cycles = 0;
    while (!mdvalid && cycles <= 2 * `RISCV_MD_CYCLES)
    begin
      #1;
      check_stalls(name, 1'b1);
      step();
      cycles++;
    end
    if (!mdvalid)
    begin
      errors++;
      $display("%s: mdvalid never rose within %0d cycles", name, cycles);
    end
    else if (cycles != `RISCV_MD_CYCLES)
    begin
      errors++;
      $display("Mismatch %s latency: expected %0d, actual %0d", name, `RISCV_MD_CYCLES, cycles);
    end
    dcache_stall = (hold > 0);
    for (i = 0; i < hold; i++)
    begin
      #1;
      check_bit({name, " mdvalid held"}, 1'b1, mdvalid);
      check_word({name, " result held"}, exp_res, mdresult);
      check_stalls({name, " held"}, 1'b1);
      step();
    end
    dcache_stall = 1'b0;
    #1;
    check_bit({name, " mdvalid"}, 1'b1, mdvalid);
    check_word({name, " result"}, exp_res, mdresult);
    check_stalls({name, " done"}, 1'b0);
    step();
    check_bit({name, " mdvalid cleared"}, 1'b0, mdvalid);
    finish_test(name, errs);
  endtask

  initial
  begin
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'h7608b69d));
    rst          = 1'b1;
    pcsrc        = 1'b0;
    dcache_stall = 1'b0;
    drive_bubble();
    rs1data_e = $urandom();
    rs2data_e = $urandom();
    result_m  = $urandom();
    uimm_m    = $urandom();
    result_w  = $urandom();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset();
    test_forwarding();
    test_load_use();
    test_branch();
    test_csr();
    run_muldiv("mul", 1'b0, $urandom(), $urandom(), 0);
    run_muldiv("div", 1'b1, $urandom(), $urandom() >> 12, 0);
    run_muldiv("div_by_zero", 1'b1, $urandom(), '0, 0);
    run_muldiv("dcache_hold", 1'b1, $urandom(), $urandom() >> 8, 3);

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hdl
hdl/riscv_pkg.sv
hdl/riscv_hazardunit.sv
hdl/riscv_ctrlpipe.sv
hdl/riscv_opfwd.sv
hdl/riscv_muldiv.sv
hdl/riscv_pipectrl_top.sv
testbench/riscv_pipectrl_assertions.sv
testbench/riscv_pipectrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module riscv_pipectrl_tb -f compile.f \
  -o riscv_pipectrl_sim > build.log 2>&1 \
  && ./obj_dir/riscv_pipectrl_sim > sim.log 2>&1 \
  || { cat build.log; echo "Testbench failed" >> sim.log; }
cat sim.log
! grep -q "Testbench failed" sim.log
